// File: build.f
+incdir+logic
logic/vjf_pkg.sv
logic/fifo.sv
logic/vertex_job_generator.sv
logic/vertex_job_filter.sv
logic/vertex_job_dispatcher.sv
logic/vertex_filter_top.sv
test/vertex_filter_asserts.sv
test/vertex_filter_checker.sv
test/vertex_filter_tb.sv

// File: Makefile
# Verilator build and run for the vertex job filter testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = vertex_filter_tb
FILE_LIST = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/vertex_filter_tb.sv
// Top-level testbench for the vertex job filter subsystem
// Loads tables, runs six sweeps and prints the closing report
// Result checks sit in the checker, credit assertions are bound into the filter

`timescale 1ns/1ps
`include "vjf_config.svh"

module vertex_filter_tb;

	localparam int ID_BITS     = `VJF_ID_BITS;
	localparam int COUNT_BITS  = `VJF_ID_BITS + 1;
	localparam int DEGREE_BITS = `VJF_DEGREE_BITS;
	localparam int PARENT_BITS = `VJF_PARENT_BITS;

	// Vertex counts of the six sweeps
	localparam int MIXED_COUNT  = 40;
	localparam int RANDOM_COUNT = 64;
	localparam int ZERO_COUNT   = 32;
	localparam int NOFLAG_COUNT = 48;
	localparam int FIRST_COUNT  = 24;
	localparam int SECOND_COUNT = 56;
	localparam int SWEEPS       = 6;
	// 20 cycles per vertex plus 200 per sweep
	localparam int WATCHDOG_CYCLES = 20 * (MIXED_COUNT + RANDOM_COUNT + ZERO_COUNT +
	                                       NOFLAG_COUNT + FIRST_COUNT + SECOND_COUNT) +
	                                 200 * SWEEPS;

	// Table kinds
	localparam int MIXED  = 0;
	localparam int RANDOM = 1;
	localparam int ZERO   = 2;
	localparam int NOFLAG = 3;
	localparam int THIRDS = 4;

	logic                        clock;
	logic                        rstn;
	logic                        table_write;
	logic [`VJF_ID_BITS-1:0]     table_addr;
	logic [`VJF_DEGREE_BITS-1:0] table_degree;
	logic [`VJF_PARENT_BITS-1:0] table_parent;
	logic                        start;
	logic [`VJF_ID_BITS:0]       vertex_count;
	logic                        result_valid;
	logic                        result_ready;
	logic [`VJF_ID_BITS-1:0]     result_vertex_id;
	logic [`VJF_DEGREE_BITS-1:0] result_degree;
	logic [`VJF_COUNT_BITS-1:0]  filtered_count;
	logic [`VJF_SUM_BITS-1:0]    degree_sum;
	logic                        done;

	int value_errors;
	int other_errors;
	int assert_errors;
	int seed;

	vertex_filter_top i_vertex_filter_top (
		.clock           (clock),
		.rstn            (rstn),
		.table_write     (table_write),
		.table_addr      (table_addr),
		.table_degree    (table_degree),
		.table_parent    (table_parent),
		.start           (start),
		.vertex_count    (vertex_count),
		.result_valid    (result_valid),
		.result_ready    (result_ready),
		.result_vertex_id(result_vertex_id),
		.result_degree   (result_degree),
		.filtered_count  (filtered_count),
		.degree_sum      (degree_sum),
		.done            (done)
	);

	vertex_filter_checker i_vertex_filter_checker (
		.clock           (clock),
		.rstn            (rstn),
		.table_write     (table_write),
		.table_addr      (table_addr),
		.table_degree    (table_degree),
		.table_parent    (table_parent),
		.start           (start),
		.vertex_count    (vertex_count),
		.result_valid    (result_valid),
		.result_ready    (result_ready),
		.result_vertex_id(result_vertex_id),
		.result_degree   (result_degree),
		.filtered_count  (filtered_count),
		.degree_sum      (degree_sum),
		.done            (done),
		.value_errors    (value_errors),
		.other_errors    (other_errors)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic write_entry(input int addr, input logic [DEGREE_BITS-1:0] degree,
	                           input logic [PARENT_BITS-1:0] parent);
		@(negedge clock);
		table_write  = 1'b1;
		table_addr   = ID_BITS'(addr);
		table_degree = degree;
		table_parent = parent;
	endtask

	// Whole table rewritten, parent MSB is the frontier flag
	task automatic load_table(input int kind);
		logic [31:0]            draw;
		logic [DEGREE_BITS-1:0] pattern;
		logic [DEGREE_BITS-1:0] degree;
		logic [PARENT_BITS-1:0] parent;
		for (int a = 0; a < `VJF_TABLE_DEPTH; a++) begin
			pattern = DEGREE_BITS'(a * 37 + 11);
			// Flag clear unless a kind sets it
			parent  = PARENT_BITS'(a * 5 + 3);
			case (kind)
				MIXED: begin
					// Filtered, pushed, discarded, discarded
					degree                = (a % 4 == 1 || a % 4 == 2) ? pattern : '0;
					parent[PARENT_BITS-1] = (a % 4 == 1 || a % 4 == 3);
				end
				RANDOM: begin
					draw   = $random(seed);
					degree = (draw[1:0] == 2'd0) ? '0 : (draw[31:16] | 16'd1);
					draw   = $random(seed);
					parent = draw[PARENT_BITS-1:0];
				end
				ZERO: degree = '0;
				NOFLAG: degree = pattern;
				default: begin
					degree                = (a % 3 == 0) ? pattern : '0;
					parent[PARENT_BITS-1] = (a % 3 == 0);
				end
			endcase
			write_entry(a, degree, parent);
		end
		@(negedge clock);
		table_write = 1'b0;
	endtask

	// Low duty ready, about one cycle in eight
	task automatic drive_ready(input bit random_ready);
		logic [31:0] draw;
		if (random_ready) begin
			draw         = $random(seed);
			result_ready = draw[2:0] == 3'd0;
		end else begin
			result_ready = 1'b1;
		end
	endtask

	task automatic run_sweep(input int count, input bit random_ready);
		@(negedge clock);
		vertex_count = COUNT_BITS'(count);
		start        = 1'b1;
		drive_ready(random_ready);
		@(negedge clock);
		start = 1'b0;
		drive_ready(random_ready);
		// done of the previous sweep clears first
		while (done) begin
			@(negedge clock);
			drive_ready(random_ready);
		end
		while (!done) begin
			@(negedge clock);
			drive_ready(random_ready);
		end
		result_ready = 1'b1;
		// Checker closes the sweep on the next rising edge
		@(negedge clock);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		seed         = 83242;
		rstn         = 1'b0;
		table_write  = 1'b0;
		table_addr   = '0;
		table_degree = '0;
		table_parent = '0;
		start        = 1'b0;
		vertex_count = '0;
		result_ready = 1'b0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		i_vertex_filter_checker.test_name = "mixed_classes";
		load_table(MIXED);
		run_sweep(MIXED_COUNT, 1'b0);

		// Back-pressure all the way to the generator
		i_vertex_filter_checker.test_name = "back_pressure";
		load_table(RANDOM);
		run_sweep(RANDOM_COUNT, 1'b1);

		i_vertex_filter_checker.test_name = "all_filtered";
		load_table(ZERO);
		run_sweep(ZERO_COUNT, 1'b0);

		i_vertex_filter_checker.test_name = "all_discarded";
		load_table(NOFLAG);
		run_sweep(NOFLAG_COUNT, 1'b0);

		// Two sweeps in a row, totals keep accumulating
		i_vertex_filter_checker.test_name = "back_to_back_first";
		load_table(THIRDS);
		run_sweep(FIRST_COUNT, 1'b0);
		i_vertex_filter_checker.test_name = "back_to_back_second";
		load_table(RANDOM);
		run_sweep(SECOND_COUNT, 1'b0);

		repeat (4) @(negedge clock);
		assert_errors = i_vertex_filter_top.i_vertex_job_filter.i_filter_asserts.failures;
		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
		         value_errors, other_errors, assert_errors);
		if ((value_errors == 0) && (other_errors == 0) && (assert_errors == 0)) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog sized from the sweep lengths
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles, a sweep never raised done",
		         WATCHDOG_CYCLES);
		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
		         value_errors, other_errors + 1,
		         i_vertex_filter_top.i_vertex_job_filter.i_filter_asserts.failures);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: test/vertex_filter_checker.sv
// Scoreboard for the vertex job filter subsystem
// Copies table writes off the load port, predicts each sweep at start,
// then checks every result transfer and the status counters at done

`timescale 1ns/1ps
`include "vjf_config.svh"

module vertex_filter_checker (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        table_write,
	input  logic [`VJF_ID_BITS-1:0]     table_addr,
	input  logic [`VJF_DEGREE_BITS-1:0] table_degree,
	input  logic [`VJF_PARENT_BITS-1:0] table_parent,
	input  logic                        start,
	input  logic [`VJF_ID_BITS:0]       vertex_count,
	input  logic                        result_valid,
	input  logic                        result_ready,
	input  logic [`VJF_ID_BITS-1:0]     result_vertex_id,
	input  logic [`VJF_DEGREE_BITS-1:0] result_degree,
	input  logic [`VJF_COUNT_BITS-1:0]  filtered_count,
	input  logic [`VJF_SUM_BITS-1:0]    degree_sum,
	input  logic                        done,
	output int                          value_errors,
	output int                          other_errors
);

	localparam int ID_BITS  = `VJF_ID_BITS;
	localparam int SUM_BITS = `VJF_SUM_BITS;

	// Set by the testbench before each sweep
	string test_name;

	// Copy of the attribute table
	logic [`VJF_DEGREE_BITS-1:0] ref_degree [`VJF_TABLE_DEPTH];
	logic [`VJF_PARENT_BITS-1:0] ref_parent [`VJF_TABLE_DEPTH];

	// Predicted results in dispatch order, totals over all sweeps
	logic [`VJF_ID_BITS-1:0]     exp_id_q [$];
	logic [`VJF_DEGREE_BITS-1:0] exp_degree_q [$];
	logic [`VJF_COUNT_BITS-1:0]  exp_filtered;
	logic [`VJF_SUM_BITS-1:0]    exp_sum;

	int   sweeps_started;
	int   sweeps_ended;
	logic done_seen;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Push on nonzero degree with frontier set, count on zero degree with it clear
	function automatic void sweep_reference(input int count);
		logic [`VJF_ID_BITS-1:0]     id;
		logic [`VJF_DEGREE_BITS-1:0] degree;
		logic                        frontier;
		for (int v = 0; v < count; v++) begin
			id       = v[ID_BITS-1:0];
			degree   = ref_degree[id];
			frontier = ref_parent[id][`VJF_PARENT_BITS-1];
			if ((degree != '0) && frontier) begin
				exp_id_q.push_back(id);
				exp_degree_q.push_back(degree);
				exp_sum = exp_sum + SUM_BITS'(degree);
			end else if ((degree == '0) && !frontier) begin
				exp_filtered = exp_filtered + 1'b1;
			end
		end
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_result();
		logic [`VJF_ID_BITS-1:0]     want_id;
		logic [`VJF_DEGREE_BITS-1:0] want_degree;
		if (exp_id_q.size() == 0) begin
			other_errors++;
			$display("Result for vertex %0d in %s arrived with no job left to dispatch",
			         result_vertex_id, test_name);
		end else begin
			want_id     = exp_id_q.pop_front();
			want_degree = exp_degree_q.pop_front();
			if (result_vertex_id !== want_id) begin
				value_errors++;
				$display("FAILED %s result_vertex_id: expected %0d, actual %0d",
				         test_name, want_id, result_vertex_id);
			end
			if (result_degree !== want_degree) begin
				value_errors++;
				$display("FAILED %s result_degree: expected 0x%0h, actual 0x%0h",
				         test_name, want_degree, result_degree);
			end
		end
	endtask

	task automatic check_sweep_end();
		sweeps_ended++;
		if (sweeps_ended != sweeps_started) begin
			other_errors++;
			$display("done rose in %s without a matching start", test_name);
		end
		if (exp_id_q.size() != 0) begin
			other_errors++;
			$display("done rose in %s with %0d expected results never delivered",
			         test_name, exp_id_q.size());
			exp_id_q.delete();
			exp_degree_q.delete();
		end
		if (filtered_count !== exp_filtered) begin
			value_errors++;
			$display("FAILED %s filtered_count: expected %0d, actual %0d",
			         test_name, exp_filtered, filtered_count);
		end
		if (degree_sum !== exp_sum) begin
			value_errors++;
			$display("FAILED %s degree_sum: expected %0d, actual %0d",
			         test_name, exp_sum, degree_sum);
		end
	endtask

	// All port values sampled on the rising edge, inputs change on the falling one
	always @(posedge clock) begin
		if (!rstn) begin
			value_errors   = 0;
			other_errors   = 0;
			exp_filtered   = '0;
			exp_sum        = '0;
			sweeps_started = 0;
			sweeps_ended   = 0;
			done_seen      = 1'b0;
		end else begin
			if (table_write) begin
				ref_degree[table_addr] = table_degree;
				ref_parent[table_addr] = table_parent;
			end
			if (start) begin
				sweep_reference(int'(vertex_count));
				sweeps_started++;
			end
			if (result_valid && result_ready) begin
				check_result();
			end
			// Rising done closes a sweep
			if (done && !done_seen) begin
				check_sweep_end();
			end
			done_seen = done;
		end
	end

endmodule

// File: test/vertex_filter_asserts.sv
// Credit and buffer assertions for the job filter
// Bound into vertex_job_filter, failure totals are read by the testbench

`timescale 1ns/1ps
`include "vjf_config.svh"

module vertex_filter_asserts (
	input logic                                     clock,
	input logic                                     rstn,
	input logic                                     push,
	input logic                                     full,
	input logic [$clog2(`VJF_QUEUE_DEPTH + 1)-1:0] disp_credits,
	input logic                                     job_valid,
	input logic                                     job_credit
);

	localparam int QCRED_BITS = $clog2(`VJF_QUEUE_DEPTH + 1);

	int push_failures;
	int range_failures;
	int return_failures;
	int failures;
	// Jobs handed to the filter and not yet paid back
	int outstanding;

	assign failures = push_failures + range_failures + return_failures;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(job_valid) - int'(job_credit);
		end
	end

	// Generator credits must keep the buffer from overflowing
	no_push_when_full: assert property (
		@(posedge clock) disable iff (!rstn) push |-> !full
	) else begin
		push_failures++;
		$error("Job pushed into a full job buffer");
	end

	credits_in_range: assert property (
		@(posedge clock) disable iff (!rstn) disp_credits <= QCRED_BITS'(`VJF_QUEUE_DEPTH)
	) else begin
		range_failures++;
		$error("Dispatcher credit count above the queue depth");
	end

	// Every returned credit pays for an earlier job
	credit_after_job: assert property (
		@(posedge clock) disable iff (!rstn) job_credit |-> outstanding > 0
	) else begin
		return_failures++;
		$error("Generator credit returned with no job outstanding");
	end

endmodule

bind vertex_job_filter vertex_filter_asserts i_filter_asserts (
	.clock       (clock),
	.rstn        (rstn),
	.push        (push),
	.full        (full),
	.disp_credits(disp_credits),
	.job_valid   (job_valid),
	.job_credit  (job_credit)
);

// File: logic/vertex_filter_top.sv
// Top level of the vertex job filter subsystem
// Host loads the attribute table, pulses start and collects results
// done marks the end of each sweep and holds until the next start

`timescale 1ns/1ps
`include "vjf_config.svh"

module vertex_filter_top (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        table_write,
	input  logic [`VJF_ID_BITS-1:0]     table_addr,
	input  logic [`VJF_DEGREE_BITS-1:0] table_degree,
	input  logic [`VJF_PARENT_BITS-1:0] table_parent,
	input  logic                        start,
	input  logic [`VJF_ID_BITS:0]       vertex_count,
	output logic                        result_valid,
	input  logic                        result_ready,
	output logic [`VJF_ID_BITS-1:0]     result_vertex_id,
	output logic [`VJF_DEGREE_BITS-1:0] result_degree,
	output logic [`VJF_COUNT_BITS-1:0]  filtered_count,
	output logic [`VJF_SUM_BITS-1:0]    degree_sum,
	output logic                        done
);

	// Generator to filter
	logic                 job_valid;
	vjf_pkg::vertex_job_t job;
	logic                 job_credit;

	// Filter to dispatcher
	logic                 disp_valid;
	vjf_pkg::vertex_job_t disp_job;
	logic                 disp_credit;

	logic                 sweep_quiet;

	vertex_job_generator i_vertex_job_generator (
		.clock       (clock),
		.rstn        (rstn),
		.table_write (table_write),
		.table_addr  (table_addr),
		.table_degree(table_degree),
		.table_parent(table_parent),
		.start       (start),
		.vertex_count(vertex_count),
		.job_valid   (job_valid),
		.job         (job),
		.job_credit  (job_credit),
		.sweep_quiet (sweep_quiet)
	);

	vertex_job_filter i_vertex_job_filter (
		.clock         (clock),
		.rstn          (rstn),
		.job_valid     (job_valid),
		.job           (job),
		.job_credit    (job_credit),
		.disp_valid    (disp_valid),
		.disp_job      (disp_job),
		.disp_credit   (disp_credit),
		.filtered_count(filtered_count)
	);

	vertex_job_dispatcher i_vertex_job_dispatcher (
		.clock           (clock),
		.rstn            (rstn),
		.disp_valid      (disp_valid),
		.disp_job        (disp_job),
		.disp_credit     (disp_credit),
		.sweep_quiet     (sweep_quiet),
		.result_valid    (result_valid),
		.result_ready    (result_ready),
		.result_vertex_id(result_vertex_id),
		.result_degree   (result_degree),
		.degree_sum      (degree_sum),
		.done            (done)
	);

endmodule

// File: logic/vertex_job_dispatcher.sv
// Vertex job dispatcher
// Small output queue in front of the result port, credit per accepted result
// Also keeps the degree sum and raises done at the end of a sweep

`timescale 1ns/1ps
`include "vjf_config.svh"

module vertex_job_dispatcher (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        disp_valid,
	input  vjf_pkg::vertex_job_t        disp_job,
	output logic                        disp_credit,
	input  logic                        sweep_quiet,
	output logic                        result_valid,
	input  logic                        result_ready,
	output logic [`VJF_ID_BITS-1:0]     result_vertex_id,
	output logic [`VJF_DEGREE_BITS-1:0] result_degree,
	output logic [`VJF_SUM_BITS-1:0]    degree_sum,
	output logic                        done
);

	localparam int QPTR_BITS  = (`VJF_QUEUE_DEPTH > 1) ? $clog2(`VJF_QUEUE_DEPTH) : 1;
	localparam int QCNT_BITS  = $clog2(`VJF_QUEUE_DEPTH + 1);
	localparam int SUM_BITS   = `VJF_SUM_BITS;

	vjf_pkg::vertex_job_t   queue [`VJF_QUEUE_DEPTH];
	logic [QPTR_BITS-1:0]   head;
	logic [QPTR_BITS-1:0]   tail;
	logic [QCNT_BITS-1:0]   count;
	logic                   accept;

	//////////////////////////////
	// Output queue
	//////////////////////////////

	// Head is visible as soon as it is written
	assign result_valid     = count != '0;
	assign result_vertex_id = queue[head].vertex_id;
	assign result_degree    = queue[head].inverse_out_degree;
	assign accept           = result_valid && result_ready;

	always_ff @(posedge clock) begin
		if (disp_valid) begin
			queue[tail] <= disp_job;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			head        <= '0;
			tail        <= '0;
			count       <= '0;
			disp_credit <= 1'b0;
			degree_sum  <= '0;
			done        <= 1'b0;
		end else begin
			// Filter credits make an enqueue into a full queue impossible
			if (disp_valid) begin
				tail <= (tail == QPTR_BITS'(`VJF_QUEUE_DEPTH - 1)) ? '0 : tail + 1'b1;
			end
			if (accept) begin
				head       <= (head == QPTR_BITS'(`VJF_QUEUE_DEPTH - 1)) ? '0 : head + 1'b1;
				degree_sum <= degree_sum + SUM_BITS'(result_degree);
			end
			count       <= count + QCNT_BITS'(disp_valid) - QCNT_BITS'(accept);
			disp_credit <= accept;
			// Falling quiet means a new sweep began
			if (!sweep_quiet) begin
				done <= 1'b0;
			end else if ((count == '0) && !disp_valid) begin
				done <= 1'b1;
			end
		end
	end

endmodule

// File: logic/vertex_job_filter.sv
// Vertex job filter
// Latches each job from the generator and pushes, counts or drops it
// Pushed jobs wait in a FIFO until the dispatcher grants a credit
// Returns one generator credit per dropped job and per pop

`timescale 1ns/1ps
`include "vjf_config.svh"

module vertex_job_filter (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_valid,
	input  vjf_pkg::vertex_job_t       job,
	output logic                       job_credit,
	output logic                       disp_valid,
	output vjf_pkg::vertex_job_t       disp_job,
	input  logic                       disp_credit,
	output logic [`VJF_COUNT_BITS-1:0] filtered_count
);

	localparam int JOB_BITS   = $bits(vjf_pkg::vertex_job_t);
	localparam int QCRED_BITS = $clog2(`VJF_QUEUE_DEPTH + 1);
	// Room for a full FIFO worth of credits plus two in one cycle
	localparam int OWE_BITS   = $clog2(`VJF_BUFFER_DEPTH + 1) + 1;

	logic                 in_valid;
	vjf_pkg::vertex_job_t in_job;

	logic frontier;
	logic has_degree;
	logic push;
	logic filter_out;
	logic not_pushed;
	logic pop;
	logic full;
	logic empty;

	logic [QCRED_BITS-1:0] disp_credits;
	logic [OWE_BITS-1:0]   owed;
	logic [OWE_BITS-1:0]   owed_total;

	//////////////////////////////
	// Input latch
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid <= 1'b0;
		end else begin
			in_valid <= job_valid;
		end
	end

	always_ff @(posedge clock) begin
		in_job <= job;
	end

	//////////////////////////////
	// Filter rule
	//////////////////////////////

	assign frontier   = in_job.parent[`VJF_PARENT_BITS-1];
	assign has_degree = |in_job.inverse_out_degree;
	// Work to do: nonzero degree on the frontier
	assign push       = in_valid && has_degree && frontier;
	// Nothing to do at all: counted
	assign filter_out = in_valid && !has_degree && !frontier;
	// Filtered or plain discard
	assign not_pushed = in_valid && !push;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			filtered_count <= '0;
		end else if (filter_out) begin
			filtered_count <= filtered_count + 1'b1;
		end
	end

	//////////////////////////////
	// Job buffer
	//////////////////////////////

	// Generator credits keep push away from a full FIFO
	fifo #(
		.WIDTH(JOB_BITS),
		.DEPTH(`VJF_BUFFER_DEPTH)
	) i_job_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (push),
		.data_in (in_job),
		.full    (full),
		.pop     (pop),
		.data_out(disp_job),
		.empty   (empty)
	);

	//////////////////////////////
	// Dispatch side
	//////////////////////////////

	assign pop = !empty && (disp_credits != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			disp_credits <= QCRED_BITS'(`VJF_QUEUE_DEPTH);
			disp_valid   <= 1'b0;
		end else begin
			disp_credits <= disp_credits - QCRED_BITS'(pop) + QCRED_BITS'(disp_credit);
			// FIFO output is registered on the same edge
			disp_valid   <= pop;
		end
	end

	//////////////////////////////
	// Generator credit return
	//////////////////////////////

	// A drop and a pop can land together, so credits queue up
	// and leave one pulse per cycle
	assign owed_total = owed + OWE_BITS'(not_pushed) + OWE_BITS'(pop);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			owed       <= '0;
			job_credit <= 1'b0;
		end else begin
			job_credit <= owed_total != '0;
			owed       <= owed_total - OWE_BITS'(owed_total != '0);
		end
	end

endmodule

// File: logic/vertex_job_generator.sv
// Vertex job generator
// Holds the host-loaded attribute table and sweeps ids 0 to vertex_count-1
// One job per cycle while credits from the filter FIFO remain

`timescale 1ns/1ps
`include "vjf_config.svh"

module vertex_job_generator (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        table_write,
	input  logic [`VJF_ID_BITS-1:0]     table_addr,
	input  logic [`VJF_DEGREE_BITS-1:0] table_degree,
	input  logic [`VJF_PARENT_BITS-1:0] table_parent,
	input  logic                        start,
	input  logic [`VJF_ID_BITS:0]       vertex_count,
	output logic                        job_valid,
	output vjf_pkg::vertex_job_t        job,
	input  logic                        job_credit,
	output logic                        sweep_quiet
);

	localparam int CREDIT_BITS = $clog2(`VJF_BUFFER_DEPTH + 1);

	// Attribute table, payload only
	logic [`VJF_DEGREE_BITS-1:0] degree_mem [`VJF_TABLE_DEPTH];
	logic [`VJF_PARENT_BITS-1:0] parent_mem [`VJF_TABLE_DEPTH];

	vjf_pkg::sweep_state_t  state;
	logic [`VJF_ID_BITS:0]  next_id;
	logic [CREDIT_BITS-1:0] credits;
	logic                   issue;
	logic                   last_id;
	logic                   credits_full;

	//////////////////////////////
	// Table load
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (table_write) begin
			degree_mem[table_addr] <= table_degree;
			parent_mem[table_addr] <= table_parent;
		end
	end

	//////////////////////////////
	// Job issue
	//////////////////////////////

	assign issue        = (state == vjf_pkg::SWEEP_ISSUE) && (credits != '0);
	assign last_id      = (next_id + 1'b1) == vertex_count;
	assign credits_full = credits == CREDIT_BITS'(`VJF_BUFFER_DEPTH);
	assign job_valid    = issue;

	// Table read straight off the current id
	always_comb begin
		job.vertex_id          = next_id[`VJF_ID_BITS-1:0];
		job.inverse_out_degree = degree_mem[next_id[`VJF_ID_BITS-1:0]];
		job.parent             = parent_mem[next_id[`VJF_ID_BITS-1:0]];
	end

	// One credit out per issued job, one back per filter pulse
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= CREDIT_BITS'(`VJF_BUFFER_DEPTH);
		end else begin
			credits <= credits - CREDIT_BITS'(issue) + CREDIT_BITS'(job_credit);
		end
	end

	//////////////////////////////
	// Sweep FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state   <= vjf_pkg::SWEEP_IDLE;
			next_id <= '0;
		end else begin
			case (state)
				vjf_pkg::SWEEP_IDLE, vjf_pkg::SWEEP_DRAIN: begin
					if (start) begin
						next_id <= '0;
						// Empty sweep skips straight to drain
						state   <= (vertex_count == '0) ? vjf_pkg::SWEEP_DRAIN
						                                : vjf_pkg::SWEEP_ISSUE;
					end
				end
				vjf_pkg::SWEEP_ISSUE: begin
					if (issue) begin
						next_id <= next_id + 1'b1;
						if (last_id) begin
							state <= vjf_pkg::SWEEP_DRAIN;
						end
					end
				end
				default: state <= vjf_pkg::SWEEP_IDLE;
			endcase
		end
	end

	// Quiet once drained and every credit is home
	// Drops for at least one cycle on a new start
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sweep_quiet <= 1'b0;
		end else begin
			sweep_quiet <= (state == vjf_pkg::SWEEP_DRAIN) && credits_full && !start;
		end
	end

endmodule

// File: logic/fifo.sv
// Synchronous FIFO with a registered read port
// data_out updates on the edge that pops, push is dropped when full

`timescale 1ns/1ps

module fifo #(
	parameter int WIDTH = 38,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign full    = count == COUNT_BITS'(DEPTH);
	assign empty   = count == '0;
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Pointers wrap at DEPTH so any depth works
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + COUNT_BITS'(do_push) - COUNT_BITS'(do_pop);
		end
	end

	// Storage and read register
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

// File: logic/vjf_pkg.sv
// Shared types for the vertex job filter subsystem
// Modules refer to these by scoped name

`include "vjf_config.svh"

package vjf_pkg;

	//////////////////////////////
	// Vertex job
	//////////////////////////////

	// One vertex worth of work, 38 bits with the default widths
	typedef struct packed {
		logic [`VJF_ID_BITS-1:0]     vertex_id;
		logic [`VJF_DEGREE_BITS-1:0] inverse_out_degree;
		// Frontier flag in the MSB
		logic [`VJF_PARENT_BITS-1:0] parent;
	} vertex_job_t;

	//////////////////////////////
	// Generator FSM
	//////////////////////////////

	typedef enum logic [1:0] {
		// Waiting for the first start after reset
		SWEEP_IDLE,
		// Walking the table
		SWEEP_ISSUE,
		// Last id issued, waiting for credits
		SWEEP_DRAIN
	} sweep_state_t;

endpackage

// File: logic/vjf_config.svh
// Sizing macros for the vertex job filter subsystem
// Included by the package and by every RTL file that needs a width or a depth

`ifndef VJF_CONFIG_SVH
`define VJF_CONFIG_SVH

// Attribute table
`define VJF_TABLE_DEPTH 64
`define VJF_ID_BITS 6
`define VJF_DEGREE_BITS 16
// MSB of the parent field is the frontier flag
`define VJF_PARENT_BITS 16

// Buffering and credits
`define VJF_BUFFER_DEPTH 8
`define VJF_QUEUE_DEPTH 2

// Status counters
`define VJF_COUNT_BITS 16
`define VJF_SUM_BITS 32

`endif
